/* list.f */
+incdir+sim
hw/pod_cfg_pkg.sv
hw/pod_link_pkg.sv
hw/wb_host_endpoint.sv
hw/pod_link_router.sv
hw/tile_mem.sv
hw/unicore_pod.sv
sim/tb_pod_gateway.sv

/* Bender.yml */
package:
  name: unicore_pod

sources:
  - hw/pod_cfg_pkg.sv
  - hw/pod_link_pkg.sv
  - hw/wb_host_endpoint.sv
  - hw/pod_link_router.sv
  - hw/tile_mem.sv
  - hw/unicore_pod.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_pod_gateway.sv

/* sim/pod_ref_model.svh */
`ifndef POD_REF_MODEL_SVH
`define POD_REF_MODEL_SVH

// host-visible memory as the gateway sees it
// local words are keyed by index, remote words by {x, index}
logic [pod_data_width_c-1:0] ref_local_mem  [logic [pod_word_addr_width_c-1:0]];
logic [pod_data_width_c-1:0] ref_remote_mem [logic [pod_addr_width_c-1:0]];
logic [pod_addr_width_c-1:0] ref_written_q  [$];  // {x, index} of each stored word, once

function automatic logic ref_is_written(input logic [pod_x_width_c-1:0]         x,
                                        input logic [pod_word_addr_width_c-1:0] idx);
  if (x == pod_local_x_c)
    return ref_local_mem.exists(idx) != 0;
  return ref_remote_mem.exists({x, idx}) != 0;
endfunction

function automatic void ref_store(input logic [pod_x_width_c-1:0]         x,
                                  input logic [pod_word_addr_width_c-1:0] idx,
                                  input logic [pod_data_width_c-1:0]      data);
  if (!ref_is_written(x, idx))
    ref_written_q.push_back({x, idx});
  if (x == pod_local_x_c)
    ref_local_mem[idx] = data;
  else
    ref_remote_mem[{x, idx}] = data;  // never touches the local word
endfunction

function automatic logic [pod_data_width_c-1:0] ref_load(
  input logic [pod_x_width_c-1:0]         x,
  input logic [pod_word_addr_width_c-1:0] idx
);
  if (x == pod_local_x_c)
    return ref_local_mem[idx];
  return ref_remote_mem[{x, idx}];
endfunction

// random word that has been stored before
function automatic logic [pod_addr_width_c-1:0] ref_pick_written();
  return ref_written_q[rand_below(ref_written_q.size())];
endfunction

`endif

/* sim/tb_pod_gateway.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pod_gateway;

  import pod_cfg_pkg::*;
  import pod_link_pkg::*;

  localparam int unsigned clk_period_c = 10;
  localparam int unsigned rst_cycles_c = 16;
  localparam int unsigned num_txn_c    = 200;
  localparam int unsigned txn_cycles_c = 40;  // budget per transaction
  localparam int unsigned max_delay_c  = 5;   // east response delay in cycles
  localparam int unsigned timeout_ns_c = (rst_cycles_c + num_txn_c * txn_cycles_c) * clk_period_c;

  logic                        blackparrot_clk = 1'b0;
  logic                        arst_n_i;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic                        wb_we_i;
  logic [pod_addr_width_c-1:0] wb_adr_i;
  logic [pod_data_width_c-1:0] wb_dat_i;
  logic [pod_data_width_c-1:0] wb_dat_o;
  logic                        wb_ack_o;
  link_sif_s                   east_link_i;
  link_sif_s                   east_link_o;

  int seed      = 52903;
  int err_cnt   = 0;
  int check_cnt = 0;
  link_pkt_s                   east_req_q [$];  // requests seen on the east link
  logic [pod_data_width_c-1:0] east_mem [logic [pod_addr_width_c-1:0]];

  unicore_pod i_dut (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .east_link_i     (east_link_i),
    .east_link_o     (east_link_o)
  );

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  `include "pod_ref_model.svh"

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp)
    else
    begin
      $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    check_cnt++;
    assert (cond === 1'b1)
    else
    begin
      $display("error at t=%0t: %s", $time, what);
      err_cnt++;
    end
  endtask

  task automatic check_idle_outputs();
    check_value("wb_ack_o", wb_ack_o, 0);
    check_value("east_link_o.v", east_link_o.v, 0);
    check_value("east_link_o.ready_rev", east_link_o.ready_rev, 0);
  endtask

  // one wishbone classic cycle from falling edge to falling edge
  task automatic wb_access(input logic we, input logic [pod_x_width_c-1:0] x,
                           input logic [pod_word_addr_width_c-1:0] idx,
                           input logic [pod_data_width_c-1:0] data);
    logic [pod_data_width_c-1:0] rdata;
    logic [pod_data_width_c-1:0] exp;
    link_pkt_s                   pkt;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {x, idx};
    wb_dat_i = data;
    do
      @(negedge blackparrot_clk);
    while (!wb_ack_o);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(negedge blackparrot_clk);
    check_cond(!wb_ack_o, "wb_ack_o stayed high for a second cycle");
    if (we)
    begin
      ref_store(x, idx, data);
      check_value("wb_dat_o", rdata, data);  // store response echoes the word
    end
    else
    begin
      exp = ref_load(x, idx);
      check_value("wb_dat_o", rdata, exp);
    end
    if (x == pod_local_x_c)
      check_value("east request count", east_req_q.size(), 0);  // local stays local
    else
    begin
      check_value("east request count", east_req_q.size(), 1);
      if (east_req_q.size() > 0)
      begin
        pkt = east_req_q.pop_front();
        check_value("east_link_o.pkt.op", pkt.op, we ? e_op_store : e_op_load);
        check_value("east_link_o.pkt.dest_x", pkt.dest_x, x);
        check_value("east_link_o.pkt.src_x", pkt.src_x, 0);
        check_value("east_link_o.pkt.addr", pkt.addr, idx);
        check_value("east_link_o.pkt.tag", pkt.tag, 0);
        if (we)
          check_value("east_link_o.pkt.data", pkt.data, data);
        else
          check_value("east responder memory", east_mem[{x, idx}], rdata);
      end
    end
    east_req_q.delete();
  endtask

  task automatic run_random_txn();
    logic                            we;
    logic [pod_x_width_c-1:0]        x;
    logic [pod_word_addr_width_c-1:0] idx;
    logic [pod_data_width_c-1:0]     data;
    logic [pod_addr_width_c-1:0]     pick;
    we   = (rand_below(2) == 1) || (ref_written_q.size() == 0);
    x    = (rand_below(2) == 0) ? 2'd0 : 2'd1;
    idx  = 8'(rand_below(tile_mem_depth_c));
    data = $random(seed);
    if (!we)
    begin
      pick = ref_pick_written();  // reads only hit stored words
      x    = pick[pod_addr_width_c-1 -: pod_x_width_c];
      idx  = pick[pod_word_addr_width_c-1:0];
    end
    wb_access(we, x, idx, data);
  endtask

  initial
  begin
    forever #(clk_period_c / 2) blackparrot_clk = ~blackparrot_clk;
  end

  initial
  begin
    #(timeout_ns_c);
    $display("watchdog: run did not finish within %0d ns", timeout_ns_c);
    $display("TEST FAILED");
    $finish;
  end

  // east neighbour pod
  initial
  begin
    link_pkt_s req;
    link_pkt_s resp;
    link_pkt_s prev_pkt;
    logic      stalled;
    logic      pending;
    logic      resp_sent;
    int        delay;
    east_link_i = '0;
    stalled     = 1'b0;
    pending     = 1'b0;
    resp_sent   = 1'b0;
    delay       = 0;
    @(posedge arst_n_i);
    forever
    begin
      @(negedge blackparrot_clk);
      if (resp_sent)
        east_link_i.v = 1'b0;  // taken on the last rising edge
      if (stalled)
        check_cond(east_link_o.v && east_link_o.pkt == prev_pkt,
                   "east request changed or vanished while ready_rev was low");
      east_link_i.ready_rev = (rand_below(4) != 0);
      stalled  = east_link_o.v && !east_link_i.ready_rev;
      prev_pkt = east_link_o.pkt;
      if (east_link_o.v && east_link_i.ready_rev)
      begin
        req = east_link_o.pkt;  // transfers on the coming edge
        east_req_q.push_back(req);
        resp.op     = e_op_resp;
        resp.dest_x = req.src_x;
        resp.src_x  = req.dest_x;
        resp.addr   = req.addr;
        resp.tag    = '0;
        if (req.op == e_op_store)
        begin
          east_mem[{req.dest_x, req.addr}] = req.data;
          resp.data = req.data;
        end
        else
          resp.data = east_mem.exists({req.dest_x, req.addr}) ?
                      east_mem[{req.dest_x, req.addr}] : '0;
        east_link_i.pkt = resp;
        pending = 1'b1;
        delay   = rand_below(max_delay_c + 1);
      end
      else if (pending && delay > 0)
        delay--;
      else if (pending)
      begin
        east_link_i.v = 1'b1;
        pending       = 1'b0;
      end
      resp_sent = east_link_i.v && east_link_o.ready_rev;
    end
  end

  initial
  begin
    int err_start;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    arst_n_i = 1'b0;
    err_start = err_cnt;
    repeat (rst_cycles_c)
    begin
      @(negedge blackparrot_clk);
      check_idle_outputs();
    end
    arst_n_i = 1'b1;
    @(negedge blackparrot_clk);
    check_idle_outputs();  // first edge after release
    $display("test reset_state finished: %0d errors", err_cnt - err_start);

    err_start = err_cnt;
    for (int n = 0; n < num_txn_c; n++)
      run_random_txn();
    $display("test mixed_traffic finished: %0d transactions, %0d errors",
             num_txn_c, err_cnt - err_start);

    // read back every stored word with local and remote side by side
    err_start = err_cnt;
    for (int i = 0; i < ref_written_q.size(); i++)
      wb_access(1'b0, ref_written_q[i][pod_addr_width_c-1 -: pod_x_width_c],
                ref_written_q[i][pod_word_addr_width_c-1:0], '0);
    $display("test isolation_readback finished: %0d words, %0d errors",
             ref_written_q.size(), err_cnt - err_start);

    $display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule : tb_pod_gateway

`default_nettype wire

/* hw/unicore_pod.sv */
`timescale 1ns/1ps
`default_nettype none

module unicore_pod (
  input  logic                                    blackparrot_clk,
  input  logic                                    arst_n_i,

  // host wishbone port
  input  logic                                    wb_cyc_i,
  input  logic                                    wb_stb_i,
  input  logic                                    wb_we_i,
  input  logic [pod_cfg_pkg::pod_addr_width_c-1:0] wb_adr_i,
  input  logic [pod_cfg_pkg::pod_data_width_c-1:0] wb_dat_i,
  output logic [pod_cfg_pkg::pod_data_width_c-1:0] wb_dat_o,
  output logic                                    wb_ack_o,

  // east link
  input  pod_link_pkg::link_sif_s                 east_link_i,
  output pod_link_pkg::link_sif_s                 east_link_o
);

  import pod_link_pkg::*;

  // endpoint <-> router
  logic      ep_req_v;
  link_pkt_s ep_req_pkt;
  logic      ep_req_ready;
  logic      ep_resp_v;
  link_pkt_s ep_resp_pkt;
  logic      ep_resp_ready;

  // router <-> tile
  logic      tile_req_v;
  link_pkt_s tile_req_pkt;
  logic      tile_req_ready;
  logic      tile_resp_v;
  link_pkt_s tile_resp_pkt;
  logic      tile_resp_ready;

  wb_host_endpoint u_endpoint (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .req_v_o         (ep_req_v),
    .req_pkt_o       (ep_req_pkt),
    .req_ready_i     (ep_req_ready),
    .resp_v_i        (ep_resp_v),
    .resp_pkt_i      (ep_resp_pkt),
    .resp_ready_o    (ep_resp_ready)
  );

  pod_link_router u_router (
    .blackparrot_clk   (blackparrot_clk),
    .arst_n_i          (arst_n_i),
    .req_v_i           (ep_req_v),
    .req_pkt_i         (ep_req_pkt),
    .req_ready_o       (ep_req_ready),
    .resp_v_o          (ep_resp_v),
    .resp_pkt_o        (ep_resp_pkt),
    .resp_ready_i      (ep_resp_ready),
    .tile_req_v_o      (tile_req_v),
    .tile_req_pkt_o    (tile_req_pkt),
    .tile_req_ready_i  (tile_req_ready),
    .tile_resp_v_i     (tile_resp_v),
    .tile_resp_pkt_i   (tile_resp_pkt),
    .tile_resp_ready_o (tile_resp_ready),
    .east_link_i       (east_link_i),
    .east_link_o       (east_link_o)
  );

  tile_mem u_tile (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .req_v_i         (tile_req_v),
    .req_pkt_i       (tile_req_pkt),
    .req_ready_o     (tile_req_ready),
    .resp_v_o        (tile_resp_v),
    .resp_pkt_o      (tile_resp_pkt),
    .resp_ready_i    (tile_resp_ready)
  );

endmodule : unicore_pod

`default_nettype wire

/* hw/tile_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_mem (
  input  logic                    blackparrot_clk,
  input  logic                    arst_n_i,

  // request in
  input  logic                    req_v_i,
  input  pod_link_pkg::link_pkt_s req_pkt_i,
  output logic                    req_ready_o,

  // response out
  output logic                    resp_v_o,
  output pod_link_pkg::link_pkt_s resp_pkt_o,
  input  logic                    resp_ready_i
);

  import pod_cfg_pkg::*;
  import pod_link_pkg::*;

  logic [pod_data_width_c-1:0] mem_q [tile_mem_depth_c];

  logic      ready_en_q;
  logic      resp_v_q;
  link_pkt_s resp_pkt_q;
  logic      req_fire;
  logic      resp_fire;

  assign req_ready_o = ready_en_q & ~resp_v_q;  // one response at a time
  assign req_fire    = req_v_i & req_ready_o;
  assign resp_v_o    = resp_v_q;
  assign resp_pkt_o  = resp_pkt_q;
  assign resp_fire   = resp_v_o & resp_ready_i;

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ready_en_q <= 1'b0;
      resp_v_q   <= 1'b0;
    end
    else
    begin
      ready_en_q <= 1'b1;
      if (req_fire)
        resp_v_q <= 1'b1;
      else if (resp_fire)
        resp_v_q <= 1'b0;
    end
  end

  // array and response payload
  always_ff @(posedge blackparrot_clk)
  begin
    if (req_fire)
    begin
      resp_pkt_q.op     <= e_op_resp;
      resp_pkt_q.dest_x <= req_pkt_i.src_x;  // back to the requester
      resp_pkt_q.src_x  <= pod_local_x_c;
      resp_pkt_q.addr   <= req_pkt_i.addr;
      resp_pkt_q.tag    <= '0;
      if (req_pkt_i.op == e_op_store)
      begin
        mem_q[req_pkt_i.addr] <= req_pkt_i.data;
        resp_pkt_q.data       <= req_pkt_i.data;  // echo written word
      end
      else
        resp_pkt_q.data <= mem_q[req_pkt_i.addr];
    end
  end

  a_req_op_legal : assert property (
    @(posedge blackparrot_clk) disable iff (!arst_n_i)
    req_fire |-> req_pkt_i.op inside {e_op_load, e_op_store}
  ) else $error("tile accepted a packet that is not a load or a store");

endmodule : tile_mem

`default_nettype wire

/* hw/pod_link_router.sv */
`timescale 1ns/1ps
`default_nettype none

module pod_link_router (
  input  logic                    blackparrot_clk,
  input  logic                    arst_n_i,

  // endpoint side
  input  logic                    req_v_i,
  input  pod_link_pkg::link_pkt_s req_pkt_i,
  output logic                    req_ready_o,
  output logic                    resp_v_o,
  output pod_link_pkg::link_pkt_s resp_pkt_o,
  input  logic                    resp_ready_i,

  // local tile side
  output logic                    tile_req_v_o,
  output pod_link_pkg::link_pkt_s tile_req_pkt_o,
  input  logic                    tile_req_ready_i,
  input  logic                    tile_resp_v_i,
  input  pod_link_pkg::link_pkt_s tile_resp_pkt_i,
  output logic                    tile_resp_ready_o,

  // east neighbour
  input  pod_link_pkg::link_sif_s east_link_i,
  output pod_link_pkg::link_sif_s east_link_o
);

  import pod_cfg_pkg::*;
  import pod_link_pkg::*;

  logic      ready_en_q;  // holds readies low until first edge after reset
  logic      req_v_q;
  link_pkt_s req_pkt_q;
  logic      out_v_q;     // a request is outstanding
  logic      out_east_q;  // ...and it went east
  logic      resp_v_q;
  link_pkt_s resp_pkt_q;

  logic      req_in_fire;
  logic      req_out_fire;
  logic      resp_side_v;
  logic      resp_in_ready;
  logic      resp_in_fire;
  logic      resp_out_fire;

  assign req_ready_o   = ready_en_q & ~out_v_q;
  assign req_in_fire   = req_v_i & req_ready_o;

  assign tile_req_v_o   = req_v_q & ~out_east_q;
  assign tile_req_pkt_o = req_pkt_q;
  assign req_out_fire   = (tile_req_v_o & tile_req_ready_i)
                        | (req_v_q & out_east_q & east_link_i.ready_rev);

  // only the side that holds the request may answer
  assign resp_in_ready     = out_v_q & ~req_v_q & ~resp_v_q;
  assign tile_resp_ready_o = resp_in_ready & ~out_east_q;
  assign resp_side_v       = out_east_q ? east_link_i.v : tile_resp_v_i;
  assign resp_in_fire      = resp_in_ready & resp_side_v;

  assign resp_v_o      = resp_v_q;
  assign resp_pkt_o    = resp_pkt_q;
  assign resp_out_fire = resp_v_o & resp_ready_i;

  always_comb
  begin
    east_link_o.v         = req_v_q & out_east_q;
    east_link_o.pkt       = req_pkt_q;
    east_link_o.ready_rev = resp_in_ready & out_east_q;
  end

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ready_en_q <= 1'b0;
      req_v_q    <= 1'b0;
      out_v_q    <= 1'b0;
      out_east_q <= 1'b0;
      resp_v_q   <= 1'b0;
    end
    else
    begin
      ready_en_q <= 1'b1;
      if (req_in_fire)
      begin
        req_v_q    <= 1'b1;
        out_v_q    <= 1'b1;
        out_east_q <= (req_pkt_i.dest_x != pod_local_x_c);  // anything not local goes east
      end
      else if (req_out_fire)
        req_v_q <= 1'b0;
      if (resp_in_fire)
      begin
        out_v_q  <= 1'b0;
        resp_v_q <= 1'b1;
      end
      else if (resp_out_fire)
        resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge blackparrot_clk)
  begin
    if (req_in_fire)
      req_pkt_q <= req_pkt_i;
    if (resp_in_fire)
      resp_pkt_q <= out_east_q ? east_link_i.pkt : tile_resp_pkt_i;
  end

  a_tile_resp_expected : assert property (
    @(posedge blackparrot_clk) disable iff (!arst_n_i)
    tile_resp_v_i |-> out_v_q && !out_east_q
  ) else $error("tile response without an outstanding tile request");

  a_east_resp_expected : assert property (
    @(posedge blackparrot_clk) disable iff (!arst_n_i)
    east_link_i.v |-> out_v_q && out_east_q
  ) else $error("east response without an outstanding east request");

  a_resp_op : assert property (
    @(posedge blackparrot_clk) disable iff (!arst_n_i)
    resp_v_o |-> resp_pkt_o.op == e_op_resp
  ) else $error("forwarded packet is not a response");

endmodule : pod_link_router

`default_nettype wire

/* hw/wb_host_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_host_endpoint (
  input  logic                                    blackparrot_clk,
  input  logic                                    arst_n_i,

  // wishbone classic slave
  input  logic                                    wb_cyc_i,
  input  logic                                    wb_stb_i,
  input  logic                                    wb_we_i,
  input  logic [pod_cfg_pkg::pod_addr_width_c-1:0] wb_adr_i,
  input  logic [pod_cfg_pkg::pod_data_width_c-1:0] wb_dat_i,
  output logic [pod_cfg_pkg::pod_data_width_c-1:0] wb_dat_o,
  output logic                                    wb_ack_o,

  // request link out
  output logic                                    req_v_o,
  output pod_link_pkg::link_pkt_s                 req_pkt_o,
  input  logic                                    req_ready_i,

  // response link in
  input  logic                                    resp_v_i,
  input  pod_link_pkg::link_pkt_s                 resp_pkt_i,
  output logic                                    resp_ready_o
);

  import pod_cfg_pkg::*;
  import pod_link_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_send,
    e_wait,
    e_ack
  } ep_state_e;

  ep_state_e state_q, state_d;
  link_pkt_s req_pkt_q;
  logic      wb_req;
  logic      req_fire;
  logic      resp_fire;

  assign wb_req    = wb_cyc_i & wb_stb_i;
  assign req_fire  = req_v_o & req_ready_i;
  assign resp_fire = resp_v_i & resp_ready_o;

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      e_idle: if (wb_req) state_d = e_send;
      e_send: if (req_fire) state_d = e_wait;
      e_wait: if (resp_fire) state_d = e_ack;
      e_ack:  state_d = e_idle;  // master drops stb after ack
      default: state_d = e_idle;
    endcase
  end

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= e_idle;
    else
      state_q <= state_d;
  end

  // packet is captured once per wishbone cycle
  always_ff @(posedge blackparrot_clk)
  begin
    if (state_q == e_idle && wb_req)
    begin
      req_pkt_q.op     <= wb_we_i ? e_op_store : e_op_load;
      req_pkt_q.dest_x <= wb_adr_i[pod_word_addr_width_c +: pod_x_width_c];
      req_pkt_q.src_x  <= pod_local_x_c;
      req_pkt_q.addr   <= wb_adr_i[pod_word_addr_width_c-1:0];
      req_pkt_q.data   <= wb_dat_i;  // ignored on a load
      req_pkt_q.tag    <= '0;
    end
    if (resp_fire)
      wb_dat_o <= resp_pkt_i.data;  // valid together with ack
  end

  assign req_v_o      = (state_q == e_send);
  assign req_pkt_o    = req_pkt_q;
  assign resp_ready_o = (state_q == e_wait);
  assign wb_ack_o     = (state_q == e_ack);

  a_req_pkt_stable : assert property (
    @(posedge blackparrot_clk) disable iff (!arst_n_i)
    req_v_o && !req_ready_i |=> $stable(req_pkt_o)
  ) else $error("endpoint request changed while stalled");

  a_ack_one_cycle : assert property (
    @(posedge blackparrot_clk) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o
  ) else $error("wishbone ack held for two cycles");

endmodule : wb_host_endpoint

`default_nettype wire

/* hw/pod_link_pkg.sv */
`default_nettype none

package pod_link_pkg;

  // packet opcodes
  typedef enum logic [1:0] {
    e_op_load  = 2'd0,  // read request
    e_op_store = 2'd1,  // write request
    e_op_resp  = 2'd2   // response to either
  } link_op_e;

  // one link packet, 76 bits
  // a load ignores data, both responses carry the word in data
  typedef struct packed {
    link_op_e                                        op;
    logic [pod_cfg_pkg::pod_x_width_c-1:0]           dest_x;
    logic [pod_cfg_pkg::pod_x_width_c-1:0]           src_x;
    logic [pod_cfg_pkg::pod_word_addr_width_c-1:0]   addr;
    logic [pod_cfg_pkg::pod_data_width_c-1:0]        data;
    logic [pod_cfg_pkg::pod_tag_width_c-1:0]         tag;  // always zero
  } link_pkt_s;

  // link bundle, 78 bits
  // ready_rev is the ready of the opposite direction on the same wires
  typedef struct packed {
    logic      v;
    link_pkt_s pkt;
    logic      ready_rev;
  } link_sif_s;

endpackage : pod_link_pkg

`default_nettype wire

/* hw/pod_cfg_pkg.sv */
`default_nettype none

package pod_cfg_pkg;

  // word and coordinate widths
  localparam int unsigned pod_data_width_c      = 32;
  localparam int unsigned pod_x_width_c         = 2;
  localparam int unsigned pod_word_addr_width_c = 8;  // word index inside one tile

  // wishbone word address is {x, word index}
  localparam int unsigned pod_addr_width_c = pod_x_width_c + pod_word_addr_width_c;

  // reserved tag bits that pad a link packet out to 76 bits
  localparam int unsigned pod_tag_width_c = 30;

  // the local tile sits at x = 0, any other x is east of us
  localparam logic [pod_x_width_c-1:0] pod_local_x_c = '0;

  // words held by the local tile
  localparam int unsigned tile_mem_depth_c = 256;

endpackage : pod_cfg_pkg

`default_nettype wire
